// ==== rtl/gat_pkg.sv ====
package gat_pkg;

  // element widths
  localparam int data_w    = 8;
  localparam int wh_elem_w = 16;
  localparam int score_w   = 32;

  // graph and layer sizes
  localparam int n_rows    = 8;
  localparam int f_in      = 16;
  localparam int f_out     = 4;
  localparam int a_depth   = 2 * f_out;
  localparam int nnz_depth = 64;

  // derived depths
  localparam int w_depth   = f_in * f_out;

  // one WH row, element j at bits j*wh_elem_w upward
  localparam int wh_row_w  = f_out * wh_elem_w;

  // address and index widths
  localparam int col_idx_w  = $clog2(f_in);
  localparam int nnz_addr_w = $clog2(nnz_depth);
  localparam int row_idx_w  = $clog2(n_rows);
  // row length runs 0 to f_in inclusive
  localparam int row_len_w  = $clog2(f_in + 1);
  localparam int w_addr_w   = $clog2(w_depth);
  localparam int a_addr_w   = $clog2(a_depth);

endpackage

// ==== rtl/w_loader.sv ====
module w_loader (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      w_valid_i,
  output logic                                      w_ready_o,
  input  logic [gat_pkg::data_w-1:0]                weight_dout_i,
  output logic [gat_pkg::w_addr_w-1:0]              weight_addr_o,
  input  logic [gat_pkg::col_idx_w-1:0]             feat_idx_i,
  output logic [gat_pkg::f_out*gat_pkg::data_w-1:0] weight_row_o
);
  import gat_pkg::*;

  logic [w_addr_w-1:0] addr_q;
  logic                started_q;
  logic                busy_q;
  logic                cap_q;
  logic [w_addr_w-1:0] cap_ptr_q;
  logic                ready_q;
  logic [data_w-1:0]   bank_q [w_depth];

  // address counter, capture trails it by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q    <= '0;
      started_q <= 1'b0;
      busy_q    <= 1'b0;
      cap_q     <= 1'b0;
      cap_ptr_q <= '0;
      ready_q   <= 1'b0;
    end else begin
      cap_q     <= busy_q;
      cap_ptr_q <= addr_q;
      if (busy_q) begin
        addr_q <= addr_q + 1'b1;
        if (addr_q == w_addr_w'(w_depth - 1)) begin
          busy_q <= 1'b0;
        end
      end else if (w_valid_i && !started_q) begin
        busy_q    <= 1'b1;
        started_q <= 1'b1;
      end
      if (cap_q && (cap_ptr_q == w_addr_w'(w_depth - 1))) begin
        ready_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cap_q) begin
      bank_q[cap_ptr_q] <= weight_dout_i;
    end
  end

  // all f_out weights of one input feature
  always_comb begin
    int base;
    base = int'(feat_idx_i) * f_out;
    for (int j = 0; j < f_out; j++) begin
      weight_row_o[j*data_w +: data_w] = bank_q[base + j];
    end
  end

  assign weight_addr_o = addr_q;
  assign w_ready_o     = ready_q;

  w_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n) w_ready_o |=> w_ready_o)
    else $error("w_ready_o fell after rising");

endmodule

// ==== rtl/a_loader.sv ====
module a_loader (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        a_valid_i,
  output logic                                        a_ready_o,
  input  logic [gat_pkg::data_w-1:0]                  a_dout_i,
  output logic [gat_pkg::a_addr_w-1:0]                a_addr_o,
  output logic [gat_pkg::a_depth*gat_pkg::data_w-1:0] a_vec_o
);
  import gat_pkg::*;

  logic [a_addr_w-1:0]       addr_q;
  logic                      started_q;
  logic                      busy_q;
  logic                      cap_q;
  logic [a_addr_w-1:0]       cap_ptr_q;
  logic                      ready_q;
  logic [a_depth*data_w-1:0] a_vec_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q    <= '0;
      started_q <= 1'b0;
      busy_q    <= 1'b0;
      cap_q     <= 1'b0;
      cap_ptr_q <= '0;
      ready_q   <= 1'b0;
    end else begin
      cap_q     <= busy_q;
      cap_ptr_q <= addr_q;
      if (busy_q) begin
        addr_q <= addr_q + 1'b1;
        if (addr_q == a_addr_w'(a_depth - 1)) begin
          busy_q <= 1'b0;
        end
      end else if (a_valid_i && !started_q) begin
        busy_q    <= 1'b1;
        started_q <= 1'b1;
      end
      // ready once the last entry is in
      if (cap_q && (cap_ptr_q == a_addr_w'(a_depth - 1))) begin
        ready_q <= 1'b1;
      end
    end
  end

  // entry k lands at bits k*data_w upward
  always_ff @(posedge clk) begin
    if (cap_q) begin
      a_vec_q[cap_ptr_q*data_w +: data_w] <= a_dout_i;
    end
  end

  assign a_addr_o  = addr_q;
  assign a_ready_o = ready_q;
  assign a_vec_o   = a_vec_q;

endmodule

// ==== rtl/spmm.sv ====
module spmm (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start_i,
  output logic                                      done_o,
  input  logic [gat_pkg::col_idx_w-1:0]             col_idx_dout_i,
  output logic [gat_pkg::nnz_addr_w-1:0]            col_idx_addr_o,
  input  logic [gat_pkg::data_w-1:0]                value_dout_i,
  output logic [gat_pkg::nnz_addr_w-1:0]            value_addr_o,
  input  logic [gat_pkg::row_len_w-1:0]             node_info_dout_i,
  output logic [gat_pkg::row_idx_w-1:0]             node_info_addr_o,
  output logic [gat_pkg::col_idx_w-1:0]             feat_idx_o,
  input  logic [gat_pkg::f_out*gat_pkg::data_w-1:0] weight_row_i,
  output logic                                      wh_we_o,
  output logic [gat_pkg::row_idx_w-1:0]             wh_waddr_o,
  output logic [gat_pkg::wh_row_w-1:0]              wh_wdata_o
);
  import gat_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_fetch,
    s_len,
    s_issue,
    s_drain,
    s_write,
    s_done
  } state_e;

  state_e               state_q;
  logic [row_idx_w-1:0] row_q;
  logic [row_len_w-1:0] cnt_q;
  // spare top bit makes an overrun visible
  logic [nnz_addr_w:0]  base_q;
  logic                 vld_q;
  logic [wh_elem_w-1:0] acc_q [f_out];
  logic [wh_elem_w-1:0] prod  [f_out];

  // products wrap to wh_elem_w bits
  always_comb begin
    for (int j = 0; j < f_out; j++) begin
      prod[j] = wh_elem_w'(value_dout_i) * wh_elem_w'(weight_row_i[j*data_w +: data_w]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= s_idle;
      row_q   <= '0;
      cnt_q   <= '0;
      base_q  <= '0;
      vld_q   <= 1'b0;
      for (int j = 0; j < f_out; j++) begin
        acc_q[j] <= '0;
      end
    end else begin
      // pair returns one cycle after its address
      vld_q <= (state_q == s_issue);
      if (vld_q) begin
        for (int j = 0; j < f_out; j++) begin
          acc_q[j] <= acc_q[j] + prod[j];
        end
      end
      case (state_q)
        s_idle: begin
          if (start_i) begin
            state_q <= s_fetch;
          end
        end
        s_fetch: state_q <= s_len;
        s_len: begin
          cnt_q   <= node_info_dout_i;
          state_q <= (node_info_dout_i == '0) ? s_write : s_issue;
        end
        s_issue: begin
          base_q <= base_q + 1'b1;
          cnt_q  <= cnt_q - 1'b1;
          if (cnt_q == row_len_w'(1)) begin
            state_q <= s_drain;
          end
        end
        // last pair accumulates here
        s_drain: state_q <= s_write;
        s_write: begin
          for (int j = 0; j < f_out; j++) begin
            acc_q[j] <= '0;
          end
          if (row_q == row_idx_w'(n_rows - 1)) begin
            state_q <= s_done;
          end else begin
            row_q   <= row_q + 1'b1;
            state_q <= s_fetch;
          end
        end
        s_done: state_q <= s_done;
        default: state_q <= s_idle;
      endcase
    end
  end

  always_comb begin
    for (int j = 0; j < f_out; j++) begin
      wh_wdata_o[j*wh_elem_w +: wh_elem_w] = acc_q[j];
    end
  end

  assign node_info_addr_o = row_q;
  assign col_idx_addr_o   = base_q[nnz_addr_w-1:0];
  assign value_addr_o     = base_q[nnz_addr_w-1:0];
  assign feat_idx_o       = col_idx_dout_i;
  assign wh_we_o          = (state_q == s_write);
  assign wh_waddr_o       = row_q;
  assign done_o           = (state_q == s_done);

  // done follows straight on the write of the last row
  done_after_last_write: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done_o) |-> ($past(wh_we_o) && ($past(wh_waddr_o) == row_idx_w'(n_rows - 1))))
    else $error("spmm done without writing the last row");

  base_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == s_issue) |-> (base_q < (nnz_addr_w + 1)'(nnz_depth)))
    else $error("nonzero pointer ran past nnz_depth");

endmodule

// ==== rtl/wh_ram.sv ====
module wh_ram (
  input  logic                          clk,
  input  logic                          we_i,
  input  logic [gat_pkg::row_idx_w-1:0] waddr_i,
  input  logic [gat_pkg::wh_row_w-1:0]  wdata_i,
  input  logic [gat_pkg::row_idx_w-1:0] raddr_i,
  output logic [gat_pkg::wh_row_w-1:0]  rdata_o
);
  import gat_pkg::*;

  logic [wh_row_w-1:0] mem_q [n_rows];
  logic [wh_row_w-1:0] rdata_q;

  // one WH row per node
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    rdata_q <= mem_q[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

// ==== rtl/dmvm.sv ====
module dmvm (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        start_i,
  input  logic [gat_pkg::a_depth*gat_pkg::data_w-1:0] a_vec_i,
  output logic [gat_pkg::row_idx_w-1:0]               wh_raddr_o,
  input  logic [gat_pkg::wh_row_w-1:0]                wh_rdata_i,
  output logic                                        score_req_o,
  input  logic                                        score_ack_i,
  output logic [gat_pkg::row_idx_w-1:0]               score_row_o,
  output logic [gat_pkg::score_w-1:0]                 score_self_o,
  output logic [gat_pkg::score_w-1:0]                 score_neigh_o,
  output logic                                        done_o
);
  import gat_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_read,
    s_calc,
    s_req,
    s_ack_low,
    s_done
  } state_e;

  state_e               state_q;
  logic [row_idx_w-1:0] row_q;
  logic                 req_q;
  logic                 done_q;
  logic [score_w-1:0]   self_q;
  logic [score_w-1:0]   neigh_q;
  logic [score_w-1:0]   self_d;
  logic [score_w-1:0]   neigh_d;

  // self uses a[0..f_out-1], neigh uses a[f_out..2*f_out-1]
  always_comb begin
    logic [score_w-1:0] wh_j;
    self_d  = '0;
    neigh_d = '0;
    for (int j = 0; j < f_out; j++) begin
      wh_j    = score_w'(wh_rdata_i[j*wh_elem_w +: wh_elem_w]);
      self_d  = self_d + score_w'(a_vec_i[j*data_w +: data_w]) * wh_j;
      neigh_d = neigh_d + score_w'(a_vec_i[(j+f_out)*data_w +: data_w]) * wh_j;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= s_idle;
      row_q   <= '0;
      req_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        s_idle: begin
          if (start_i) begin
            state_q <= s_read;
          end
        end
        s_read: state_q <= s_calc;
        s_calc: begin
          req_q   <= 1'b1;
          state_q <= s_req;
        end
        s_req: begin
          if (score_ack_i) begin
            req_q   <= 1'b0;
            state_q <= s_ack_low;
          end
        end
        // next row only once ack is seen low
        s_ack_low: begin
          if (!score_ack_i) begin
            if (row_q == row_idx_w'(n_rows - 1)) begin
              done_q  <= 1'b1;
              state_q <= s_done;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= s_read;
            end
          end
        end
        s_done: state_q <= s_done;
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == s_calc) begin
      self_q  <= self_d;
      neigh_q <= neigh_d;
    end
  end

  assign wh_raddr_o    = row_q;
  assign score_req_o   = req_q;
  assign score_row_o   = row_q;
  assign score_self_o  = self_q;
  assign score_neigh_o = neigh_q;
  assign done_o        = done_q;

  scores_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (score_req_o && !score_ack_i) |=>
      ($stable(score_row_o) && $stable(score_self_o) && $stable(score_neigh_o)))
    else $error("score data changed while waiting for ack");

endmodule

// ==== rtl/scheduler.sv ====
module scheduler (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [gat_pkg::col_idx_w-1:0]  h_col_idx_dout_i,
  output logic [gat_pkg::nnz_addr_w-1:0] h_col_idx_addr_o,
  input  logic                           h_col_idx_load_done_i,
  input  logic [gat_pkg::data_w-1:0]     h_value_dout_i,
  output logic [gat_pkg::nnz_addr_w-1:0] h_value_addr_o,
  input  logic                           h_value_load_done_i,
  input  logic [gat_pkg::row_len_w-1:0]  h_node_info_dout_i,
  output logic [gat_pkg::row_idx_w-1:0]  h_node_info_addr_o,
  input  logic                           h_node_info_load_done_i,
  input  logic [gat_pkg::data_w-1:0]     weight_dout_i,
  output logic [gat_pkg::w_addr_w-1:0]   weight_addr_o,
  input  logic                           weight_load_done_i,
  input  logic [gat_pkg::data_w-1:0]     a_dout_i,
  output logic [gat_pkg::a_addr_w-1:0]   a_addr_o,
  input  logic                           a_load_done_i,
  output logic                           score_req_o,
  input  logic                           score_ack_i,
  output logic [gat_pkg::row_idx_w-1:0]  score_row_o,
  output logic [gat_pkg::score_w-1:0]    score_self_o,
  output logic [gat_pkg::score_w-1:0]    score_neigh_o,
  output logic                           done_o
);
  import gat_pkg::*;

  logic                      w_ready;
  logic                      a_ready;
  logic [a_depth*data_w-1:0] a_vec;
  logic [col_idx_w-1:0]      feat_idx;
  logic [f_out*data_w-1:0]   weight_row;
  logic                      spmm_start;
  logic                      spmm_done;
  logic                      dmvm_start_q;
  logic                      wh_we;
  logic [row_idx_w-1:0]      wh_waddr;
  logic [wh_row_w-1:0]       wh_wdata;
  logic [row_idx_w-1:0]      wh_raddr;
  logic [wh_row_w-1:0]       wh_rdata;

  w_loader u_w_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .w_valid_i     (weight_load_done_i),
    .w_ready_o     (w_ready),
    .weight_dout_i (weight_dout_i),
    .weight_addr_o (weight_addr_o),
    .feat_idx_i    (feat_idx),
    .weight_row_o  (weight_row)
  );

  a_loader u_a_loader (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_valid_i (a_load_done_i),
    .a_ready_o (a_ready),
    .a_dout_i  (a_dout_i),
    .a_addr_o  (a_addr_o),
    .a_vec_o   (a_vec)
  );

  // H fully loaded and W banked
  assign spmm_start = h_col_idx_load_done_i && h_value_load_done_i &&
                      h_node_info_load_done_i && weight_load_done_i && w_ready;

  spmm u_spmm (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (spmm_start),
    .done_o           (spmm_done),
    .col_idx_dout_i   (h_col_idx_dout_i),
    .col_idx_addr_o   (h_col_idx_addr_o),
    .value_dout_i     (h_value_dout_i),
    .value_addr_o     (h_value_addr_o),
    .node_info_dout_i (h_node_info_dout_i),
    .node_info_addr_o (h_node_info_addr_o),
    .feat_idx_o       (feat_idx),
    .weight_row_i     (weight_row),
    .wh_we_o          (wh_we),
    .wh_waddr_o       (wh_waddr),
    .wh_wdata_o       (wh_wdata)
  );

  wh_ram u_wh_ram (
    .clk     (clk),
    .we_i    (wh_we),
    .waddr_i (wh_waddr),
    .wdata_i (wh_wdata),
    .raddr_i (wh_raddr),
    .rdata_o (wh_rdata)
  );

  // sticky once WH is complete and a is banked
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dmvm_start_q <= 1'b0;
    end else if (spmm_done && a_ready) begin
      dmvm_start_q <= 1'b1;
    end
  end

  dmvm u_dmvm (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (dmvm_start_q),
    .a_vec_i       (a_vec),
    .wh_raddr_o    (wh_raddr),
    .wh_rdata_i    (wh_rdata),
    .score_req_o   (score_req_o),
    .score_ack_i   (score_ack_i),
    .score_row_o   (score_row_o),
    .score_self_o  (score_self_o),
    .score_neigh_o (score_neigh_o),
    .done_o        (done_o)
  );

endmodule

// ==== dv/tb_rom.sv ====
module tb_rom #(
  parameter int data_bits = 8,
  parameter int depth     = 64,
  parameter int addr_bits = $clog2(depth)
) (
  input  logic                 clk,
  input  logic [addr_bits-1:0] addr_i,
  output logic [data_bits-1:0] dout_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // contents written straight from the testbench
  logic [data_bits-1:0] mem [depth];
  logic [data_bits-1:0] dout_q = '0;

  // one clock of read latency
  always @(posedge clk) begin
    dout_q <= mem[addr_i];
  end

  assign dout_o = dout_q;

endmodule

// ==== dv/tb_scheduler.sv ====
module tb_scheduler;
  timeunit 1ns;
  timeprecision 1ps;
  import gat_pkg::*;

  logic                  clk;
  logic                  rst_n;
  // bit 0 col_idx, 1 value, 2 node_info, 3 weight, 4 a
  logic [4:0]            load_flags;
  logic                  score_ack;
  logic [nnz_addr_w-1:0] col_addr;
  logic [col_idx_w-1:0]  col_dout;
  logic [nnz_addr_w-1:0] val_addr;
  logic [data_w-1:0]     val_dout;
  logic [row_idx_w-1:0]  info_addr;
  logic [row_len_w-1:0]  info_dout;
  logic [w_addr_w-1:0]   w_addr;
  logic [data_w-1:0]     w_dout;
  logic [a_addr_w-1:0]   a_addr;
  logic [data_w-1:0]     a_dout;
  logic                  score_req;
  logic [row_idx_w-1:0]  score_row;
  logic [score_w-1:0]    score_self;
  logic [score_w-1:0]    score_neigh;
  logic                  done;

  // current graph
  int h_len [n_rows];
  int h_col [nnz_depth];
  int h_val [nnz_depth];
  int w_mem [w_depth];
  int a_mem [a_depth];

  logic [score_w-1:0] exp_self   [n_rows];
  logic [score_w-1:0] exp_neigh  [n_rows];
  logic [score_w-1:0] got_self   [n_rows];
  logic [score_w-1:0] got_neigh  [n_rows];
  logic [score_w-1:0] fast_self  [n_rows];
  logic [score_w-1:0] fast_neigh [n_rows];

  int errors;
  int gate_errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  bit aborted;

  tb_rom #(.data_bits(col_idx_w), .depth(nnz_depth)) rom_col (
    .clk(clk), .addr_i(col_addr), .dout_o(col_dout));
  tb_rom #(.data_bits(data_w), .depth(nnz_depth)) rom_val (
    .clk(clk), .addr_i(val_addr), .dout_o(val_dout));
  tb_rom #(.data_bits(row_len_w), .depth(n_rows)) rom_info (
    .clk(clk), .addr_i(info_addr), .dout_o(info_dout));
  tb_rom #(.data_bits(data_w), .depth(w_depth)) rom_w (
    .clk(clk), .addr_i(w_addr), .dout_o(w_dout));
  tb_rom #(.data_bits(data_w), .depth(a_depth)) rom_a (
    .clk(clk), .addr_i(a_addr), .dout_o(a_dout));

  scheduler dut (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .h_col_idx_dout_i        (col_dout),
    .h_col_idx_addr_o        (col_addr),
    .h_col_idx_load_done_i   (load_flags[0]),
    .h_value_dout_i          (val_dout),
    .h_value_addr_o          (val_addr),
    .h_value_load_done_i     (load_flags[1]),
    .h_node_info_dout_i      (info_dout),
    .h_node_info_addr_o      (info_addr),
    .h_node_info_load_done_i (load_flags[2]),
    .weight_dout_i           (w_dout),
    .weight_addr_o           (w_addr),
    .weight_load_done_i      (load_flags[3]),
    .a_dout_i                (a_dout),
    .a_addr_o                (a_addr),
    .a_load_done_i           (load_flags[4]),
    .score_req_o             (score_req),
    .score_ack_i             (score_ack),
    .score_row_o             (score_row),
    .score_self_o            (score_self),
    .score_neigh_o           (score_neigh),
    .done_o                  (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // nothing may leave the DUT while a memory is still loading
  always @(negedge clk) begin
    if (rst_n && (load_flags != 5'b11111)) begin
      assert (!score_req && !done) else begin
        gate_errors++;
        $display("error: req or done went high while a load flag was still low");
      end
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("error: %s %s expected %0h actual %0h", test, field, expected, actual);
  endtask

  task automatic report_failure(input string test, input string what);
    errors++;
    $display("error: %s: %s", test, what);
  endtask

  task automatic begin_test();
    err_mark = errors + gate_errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors + gate_errors == err_mark) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors + gate_errors - err_mark);
    end
  endtask

  // mode 0 random, 1 all rows empty, 2 one full row, 3 all values at maximum
  task automatic gen_graph(input int mode);
    int total;
    int len;
    int limit;
    int full_row;
    int r;
    int tmp;
    int perm [f_in];
    total = 0;
    full_row = $urandom_range(n_rows - 1, 0);
    for (int i = 0; i < n_rows; i++) begin
      case (mode)
        1: len = 0;
        3: len = nnz_depth / n_rows;
        default: len = $urandom_range(f_in, 0);
      endcase
      // keep room for the full row still to come
      limit = nnz_depth - total - (((mode == 2) && (i < full_row)) ? f_in : 0);
      if (mode == 2 && i == full_row) begin
        len = f_in;
      end
      if (len > limit) begin
        len = limit;
      end
      h_len[i] = len;
      for (int k = 0; k < f_in; k++) begin
        perm[k] = k;
      end
      for (int k = f_in - 1; k > 0; k--) begin
        r = $urandom_range(k, 0);
        tmp = perm[k];
        perm[k] = perm[r];
        perm[r] = tmp;
      end
      for (int k = 0; k < len; k++) begin
        h_col[total + k] = perm[k];
        h_val[total + k] = (mode == 3) ? 255 : $urandom_range(255, 0);
      end
      total = total + len;
    end
    for (int k = total; k < nnz_depth; k++) begin
      h_col[k] = 0;
      h_val[k] = 0;
    end
    for (int k = 0; k < w_depth; k++) begin
      w_mem[k] = (mode == 3) ? 255 : $urandom_range(255, 0);
    end
    for (int k = 0; k < a_depth; k++) begin
      a_mem[k] = (mode == 3) ? 255 : $urandom_range(255, 0);
    end
  endtask

  // WH wraps at 16 bits, scores are exact at 32
  function automatic void compute_model();
    logic [wh_elem_w-1:0] wh [f_out];
    int p;
    int idx;
    p = 0;
    for (int i = 0; i < n_rows; i++) begin
      for (int j = 0; j < f_out; j++) begin
        wh[j] = '0;
        for (int k = 0; k < h_len[i]; k++) begin
          idx = p + k;
          wh[j] = wh[j] + wh_elem_w'(h_val[idx] * w_mem[h_col[idx] * f_out + j]);
        end
      end
      exp_self[i] = '0;
      exp_neigh[i] = '0;
      for (int j = 0; j < f_out; j++) begin
        exp_self[i] = exp_self[i] + score_w'(a_mem[j]) * score_w'(wh[j]);
        exp_neigh[i] = exp_neigh[i] + score_w'(a_mem[f_out + j]) * score_w'(wh[j]);
      end
      p = p + h_len[i];
    end
  endfunction

  task automatic load_roms();
    for (int k = 0; k < nnz_depth; k++) begin
      rom_col.mem[k] = col_idx_w'(h_col[k]);
      rom_val.mem[k] = data_w'(h_val[k]);
    end
    for (int i = 0; i < n_rows; i++) begin
      rom_info.mem[i] = row_len_w'(h_len[i]);
    end
    for (int k = 0; k < w_depth; k++) begin
      rom_w.mem[k] = data_w'(w_mem[k]);
    end
    for (int k = 0; k < a_depth; k++) begin
      rom_a.mem[k] = data_w'(a_mem[k]);
    end
  endtask

  task automatic apply_reset(input string name);
    rst_n = 1'b0;
    load_flags = '0;
    score_ack = 1'b0;
    repeat (2) begin
      tick();
      assert (score_req === 1'b0 && done === 1'b0)
        else report_failure(name, "req or done high during reset");
    end
  endtask

  task automatic raise_flags();
    int rise_at [5];
    for (int f = 0; f < 5; f++) begin
      rise_at[f] = $urandom_range(20, 0);
    end
    for (int c = 0; c <= 20; c++) begin
      for (int f = 0; f < 5; f++) begin
        if (c == rise_at[f]) begin
          load_flags = load_flags | (5'b00001 << f);
        end
      end
      tick();
    end
  endtask

  task automatic wait_for_req(input logic level, input int limit, input string name,
                              output bit ok);
    int n;
    n = 0;
    while (score_req !== level && n < limit) begin
      tick();
      n++;
    end
    ok = (score_req === level);
    if (!ok) begin
      report_failure(name, $sformatf("timed out waiting for score_req to become %0b", level));
      aborted = 1'b1;
    end
  endtask

  task automatic wait_for_done(input int limit, input string name, output bit ok);
    int n;
    n = 0;
    while (done !== 1'b1 && n < limit) begin
      tick();
      n++;
    end
    ok = (done === 1'b1);
    if (!ok) begin
      report_failure(name, "timed out waiting for done after the last score");
      aborted = 1'b1;
    end
  endtask

  // stops with req pending when transfer stop_after shows up
  task automatic run_graph(input string name, input int ack_max, input int stop_after);
    bit ok;
    int delay;
    logic [row_idx_w-1:0] row_s;
    logic [score_w-1:0]   self_s;
    logic [score_w-1:0]   neigh_s;
    if (aborted) return;
    apply_reset(name);
    load_roms();
    rst_n = 1'b1;
    raise_flags();
    for (int t = 0; t < n_rows; t++) begin
      wait_for_req(1'b1, 3000, name, ok);
      if (!ok) return;
      if (t == stop_after) return;
      row_s = score_row;
      self_s = score_self;
      neigh_s = score_neigh;
      assert (row_s == row_idx_w'(t)) else report_mismatch(name, "row", t, 32'(row_s));
      assert (self_s == exp_self[t])
        else report_mismatch(name, $sformatf("self row %0d", t), exp_self[t], self_s);
      assert (neigh_s == exp_neigh[t])
        else report_mismatch(name, $sformatf("neigh row %0d", t), exp_neigh[t], neigh_s);
      assert (!done) else report_failure(name, "done high before the last score");
      got_self[t] = self_s;
      got_neigh[t] = neigh_s;
      delay = $urandom_range(ack_max, 0);
      repeat (delay) begin
        tick();
        assert (score_req && score_row == row_s && score_self == self_s &&
                score_neigh == neigh_s)
          else report_failure(name, "req dropped or score data changed before ack");
      end
      score_ack = 1'b1;
      wait_for_req(1'b0, 20, name, ok);
      if (!ok) return;
      delay = $urandom_range(ack_max, 0);
      repeat (delay) begin
        tick();
        assert (!score_req)
          else report_failure(name, "req rose again while ack was still high");
      end
      score_ack = 1'b0;
    end
    wait_for_done(20, name, ok);
    if (!ok) return;
    repeat (20) begin
      tick();
      assert (!score_req && done) else report_failure(name, "req rose or done fell at the end");
    end
  endtask

  task automatic test_reset_state();
    begin_test();
    gen_graph(0);
    // each missing flag on its own must hold the whole pipeline
    for (int f = 0; f < 5; f++) begin
      apply_reset("reset_state");
      load_roms();
      rst_n = 1'b1;
      load_flags = 5'b11111 & ~(5'b00001 << f);
      repeat (300) begin
        tick();
        assert (!score_req && !done)
          else report_failure("reset_state", "req or done high with one load flag low");
      end
    end
    end_test("reset_state");
  endtask

  task automatic test_graph(input string name, input int mode);
    begin_test();
    gen_graph(mode);
    compute_model();
    run_graph(name, 5, n_rows);
    end_test(name);
  endtask

  task automatic test_backpressure();
    begin_test();
    gen_graph(0);
    compute_model();
    run_graph("backpressure", 0, n_rows);
    for (int t = 0; t < n_rows; t++) begin
      fast_self[t] = got_self[t];
      fast_neigh[t] = got_neigh[t];
    end
    run_graph("backpressure", 12, n_rows);
    for (int t = 0; t < n_rows; t++) begin
      assert (got_self[t] == fast_self[t])
        else report_mismatch("backpressure", "self against fast ack", fast_self[t],
                             got_self[t]);
      assert (got_neigh[t] == fast_neigh[t])
        else report_mismatch("backpressure", "neigh against fast ack", fast_neigh[t],
                             got_neigh[t]);
    end
    end_test("backpressure");
  endtask

  task automatic test_reset_mid_run();
    begin_test();
    gen_graph(0);
    compute_model();
    run_graph("reset_mid_run", 5, 3);
    // fresh graph, the reset happens with row 3 still pending
    gen_graph(0);
    compute_model();
    run_graph("reset_mid_run", 5, n_rows);
    end_test("reset_mid_run");
  endtask

  initial begin
    rst_n = 1'b0;
    load_flags = '0;
    score_ack = 1'b0;
    errors = 0;
    gate_errors = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    void'($urandom(81538));
    test_reset_state();
    for (int r = 0; r < 10; r++) begin
      test_graph($sformatf("random_%0d", r), 0);
    end
    test_graph("corner_empty", 1);
    test_graph("corner_full_row", 2);
    test_graph("corner_max_values", 3);
    test_backpressure();
    test_reset_mid_run();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             errors + gate_errors);
    if (errors + gate_errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
rtl/gat_pkg.sv
rtl/w_loader.sv
rtl/a_loader.sv
rtl/spmm.sv
rtl/wh_ram.sv
rtl/dmvm.sv
rtl/scheduler.sv
dv/tb_rom.sv
dv/tb_scheduler.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_scheduler -f all.f -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log
grep -qx "Everything OK" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
